// File: files.f
+incdir+.
sdp_rdma_ig_pkg.sv
sdp_rdma_ig_size_calc.sv
sdp_rdma_ig_cube_walker.sv
sdp_rdma_ig_addr_gen.sv
sdp_rdma_ig_stall_cnt.sv
sdp_rdma_ig_top.sv
tb_sdp_rdma_ig_checker.sv
tb_sdp_rdma_ig.sv

// File: Makefile
# Verilator build for the sdp rdma ingress command generator testbench

VERILATOR ?= verilator
TOP       ?= tb_sdp_rdma_ig
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)

check: run
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_sdp_rdma_ig.sv
/*
 * testbench top for the sdp rdma ingress command generator
 * clock, reset, lfsr stimulus, dut and checker instances
 */
`timescale 1ns/1ps
`include "sdp_rdma_ig_cfg.svh"

module tb_sdp_rdma_ig;

  localparam int NUM_OPS    = 40;
  localparam int OP_TIMEOUT = 4000;

  logic                                  nvdla_core_clk;
  logic                                  nvdla_core_rstn;
  logic                                  op_load;
  sdp_rdma_ig_pkg::sdp_rdma_ig_cfg_t     cfg;
  sdp_rdma_ig_pkg::sdp_rdma_ig_dma_req_t dma_rd_req;
  logic                                  dma_rd_req_vld;
  logic                                  dma_rd_req_rdy;
  sdp_rdma_ig_pkg::sdp_rdma_ig_cq_req_t  cq_req;
  logic                                  cq_vld;
  logic                                  cq_rdy;
  logic [`SDP_RDMA_STALL_WIDTH-1:0]      rdma_stall;

  logic [15:0] lfsr_state;
  int          timeouts;
  int          error_total;
  logic        report;
  logic        stop_run;

  sdp_rdma_ig_top DUT (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cfg             (cfg),
    .dma_rd_req      (dma_rd_req),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .cq_req          (cq_req),
    .cq_vld          (cq_vld),
    .cq_rdy          (cq_rdy),
    .rdma_stall      (rdma_stall)
  );

  tb_sdp_rdma_ig_checker u_checker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cfg             (cfg),
    .dma_rd_req      (dma_rd_req),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .cq_req          (cq_req),
    .cq_vld          (cq_vld),
    .cq_rdy          (cq_rdy),
    .rdma_stall      (rdma_stall),
    .timeouts        (timeouts),
    .report          (report),
    .error_total     (error_total)
  );

  // 20 ns clock
  initial begin
    nvdla_core_clk = 1'b0;
    forever #10 nvdla_core_clk = ~nvdla_core_clk;
  end

  // ============================================================
  // random source
  // ============================================================
  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    logic        lsb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
        lfsr_state = lfsr_state ^ 16'hB400;
      end
      v = {v[30:0], lsb};
    end
    return v;
  endfunction

  // roughly 70 percent high on each side
  task automatic drive_readies();
    dma_rd_req_rdy = (next_bits(4) < 11);
    cq_rdy         = (next_bits(4) < 11);
  endtask

  task automatic randomize_cfg();
    logic [1:0] use_code;
    cfg.channel = 13'(next_bits(6));
    cfg.height  = 13'(next_bits(3));
    cfg.width   = 13'(next_bits(3));
    // now and then a 1x1 cube
    if (next_bits(3) == 0) begin
      cfg.height = '0;
      cfg.width  = '0;
    end
    // per kernel about one run in eight
    cfg.data_mode = (next_bits(3) != 0);
    cfg.precision = 2'(next_bits(1));
    // int16 only comes with two-byte elements
    if (cfg.precision == `SDP_RDMA_PREC_INT8) begin
      cfg.data_size = 1'(next_bits(1));
    end else begin
      cfg.data_size = 1'b1;
    end
    use_code = 2'(next_bits(2));
    cfg.data_use    = (use_code == 2'd3) ? 2'd2 : use_code;
    cfg.base_addr   = 29'(next_bits(29));
    cfg.line_stride = 29'(next_bits(29));
    cfg.surf_stride = 29'(next_bits(29));
    cfg.op_en       = (next_bits(3) != 0);
    cfg.perf_dma_en = (next_bits(3) != 0);
  endtask

  // ============================================================
  // one operation, load then wait for the cube end accept
  // ============================================================
  task automatic run_operation(input int idx);
    int   cycles;
    logic done;
    @(posedge nvdla_core_clk);
    #2;
    randomize_cfg();
    op_load = 1'b1;
    drive_readies();
    @(posedge nvdla_core_clk);
    #2;
    op_load = 1'b0;
    drive_readies();
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < OP_TIMEOUT) begin
      @(posedge nvdla_core_clk);
      if (dma_rd_req_vld && dma_rd_req_rdy && cq_req.cube_end) begin
        done = 1'b1;
      end else begin
        #2;
        drive_readies();
        cycles++;
      end
    end
    if (!done) begin
      timeouts++;
      stop_run = 1'b1;
      $display("operation %0d did not finish within %0d cycles", idx, OP_TIMEOUT);
    end
  endtask

  initial begin
    lfsr_state      = 16'd43505;
    nvdla_core_rstn = 1'b0;
    op_load         = 1'b0;
    cfg             = '0;
    dma_rd_req_rdy  = 1'b0;
    cq_rdy          = 1'b0;
    timeouts        = 0;
    report          = 1'b0;
    stop_run        = 1'b0;
    repeat (10) @(posedge nvdla_core_clk);
    #2;
    nvdla_core_rstn = 1'b1;
    for (int i = 0; i < NUM_OPS && !stop_run; i++) begin
      run_operation(i);
    end
    // valids must stay low once idle
    repeat (4) @(posedge nvdla_core_clk);
    report = 1'b1;
    #1;
    if (error_total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: tb_sdp_rdma_ig_checker.sv
/*
 * reference model and comparisons for the ingress command generator
 * expected request list, handshake pairing, stall count, closing counts
 */
`timescale 1ns/1ps
`include "sdp_rdma_ig_cfg.svh"

module tb_sdp_rdma_ig_checker (
  input  logic                                  nvdla_core_clk,
  input  logic                                  nvdla_core_rstn,
  input  logic                                  op_load,
  input  sdp_rdma_ig_pkg::sdp_rdma_ig_cfg_t     cfg,
  input  sdp_rdma_ig_pkg::sdp_rdma_ig_dma_req_t dma_rd_req,
  input  logic                                  dma_rd_req_vld,
  input  logic                                  dma_rd_req_rdy,
  input  sdp_rdma_ig_pkg::sdp_rdma_ig_cq_req_t  cq_req,
  input  logic                                  cq_vld,
  input  logic                                  cq_rdy,
  input  logic [`SDP_RDMA_STALL_WIDTH-1:0]      rdma_stall,
  input  int                                    timeouts,
  input  logic                                  report,
  output int                                    error_total
);

  typedef struct packed {
    logic [`SDP_RDMA_ADDR_WIDTH-1:0] addr;
    logic [`SDP_RDMA_SIZE_WIDTH-1:0] size;
    logic                            cube_end;
  } exp_req_t;

  exp_req_t                         exp_q[$];
  exp_req_t                         cur_req;
  logic                             busy;
  logic [`SDP_RDMA_STALL_WIDTH-1:0] stall_model;
  int                               value_errs;
  int                               protocol_errs;
  int                               req_cnt;

  assign error_total = value_errs + protocol_errs + timeouts;

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      value_errs++;
      $display("Error: %s expected 0x%h got 0x%h at request %0d", name, exp, got, req_cnt);
    end
  endtask

  // ============================================================
  // expected request list from the configuration
  // ============================================================
  task automatic build_expected(input sdp_rdma_ig_pkg::sdp_rdma_ig_cfg_t c);
    int                                              surfs;
    int                                              k;
    int                                              units;
    logic                                            single;
    logic [`SDP_RDMA_ADDR_WIDTH-`SDP_RDMA_ATOM_SHIFT-1:0] atom;
    exp_req_t                                        e;
    // 8 int8 channels per surface, 4 otherwise
    if (c.precision == `SDP_RDMA_PREC_INT8) begin
      surfs = int'(c.channel) / 8;
      if (c.data_use == 2'd2) begin
        k = c.data_size ? 4 : 2;
      end else begin
        k = c.data_size ? 2 : 1;
      end
    end else begin
      surfs = int'(c.channel) / 4;
      k = (c.data_use == 2'd2) ? 2 : 1;
    end
    single = (c.data_mode == 1'b0) || (c.width == '0 && c.height == '0);
    units  = single ? surfs + 1 : int'(c.width) + 1;
    e.size = 15'(units * k - 1);
    if (single) begin
      e.addr     = {c.base_addr, 3'b000};
      e.cube_end = 1'b1;
      exp_q.push_back(e);
    end else begin
      for (int s = 0; s <= surfs; s++) begin
        for (int h = 0; h <= int'(c.height); h++) begin
          atom = c.base_addr + 29'(s) * c.surf_stride + 29'(h) * c.line_stride;
          e.addr     = {atom, 3'b000};
          e.cube_end = (s == surfs) && (h == int'(c.height));
          exp_q.push_back(e);
        end
      end
    end
  endtask

  // ============================================================
  // per-cycle checks, sampled at the rising edge
  // ============================================================
  always @(posedge nvdla_core_clk) begin
    if (!nvdla_core_rstn) begin
      busy        = 1'b0;
      stall_model = '0;
      exp_q.delete();
    end else begin
      // dma and context queue must transfer together
      if ((dma_rd_req_vld && dma_rd_req_rdy) != (cq_vld && cq_rdy)) begin
        protocol_errs++;
        $display("dma and context queue transfers happened in different cycles");
      end
      if (!busy && (dma_rd_req_vld || cq_vld)) begin
        protocol_errs++;
        $display("a valid was high while no operation was running");
      end
      // while busy each valid follows the other side's ready
      if (busy && (dma_rd_req_vld !== cq_rdy || cq_vld !== dma_rd_req_rdy)) begin
        protocol_errs++;
        $display("a valid did not follow the other side's ready during an operation");
      end
      check_value("rdma_stall", stall_model, rdma_stall);
      if (dma_rd_req_vld && dma_rd_req_rdy) begin
        if (exp_q.size() == 0) begin
          protocol_errs++;
          $display("a request was accepted but none was expected");
        end else begin
          cur_req = exp_q.pop_front();
          check_value("dma_rd_req.addr", cur_req.addr, dma_rd_req.addr);
          check_value("dma_rd_req.size", 32'(cur_req.size), 32'(dma_rd_req.size));
          check_value("cq_req.size", 32'(cur_req.size), 32'(cq_req.size));
          check_value("cq_req.cube_end", 32'(cur_req.cube_end), 32'(cq_req.cube_end));
          req_cnt++;
          if (cur_req.cube_end) begin
            busy = 1'b0;
          end
        end
      end
      // stall model, held while perf counting is off
      if (cfg.op_en && cfg.perf_dma_en) begin
        if (op_load) begin
          stall_model = '0;
        end else if (dma_rd_req_vld && !dma_rd_req_rdy) begin
          stall_model = stall_model + 32'd1;
        end
      end
      if (op_load) begin
        build_expected(cfg);
        busy = 1'b1;
      end
    end
  end

  // closing line with every count
  always @(posedge report) begin
    if (exp_q.size() != 0) begin
      protocol_errs++;
      $display("%0d expected requests were never sent", exp_q.size());
    end
    $display("requests %0d, value errors %0d, protocol errors %0d, timeouts %0d",
             req_cnt, value_errs, protocol_errs, timeouts);
  end

  initial begin
    value_errs    = 0;
    protocol_errs = 0;
    req_cnt       = 0;
  end

endmodule

// File: sdp_rdma_ig_top.sv
/*
 * top of the sdp rdma ingress command generator
 * size calc, cube walker, address generator and stall counter
 */
`timescale 1ns/1ps
`include "sdp_rdma_ig_cfg.svh"

module sdp_rdma_ig_top (
  input  logic                                  nvdla_core_clk,
  input  logic                                  nvdla_core_rstn,
  input  logic                                  op_load,
  input  sdp_rdma_ig_pkg::sdp_rdma_ig_cfg_t     cfg,
  // dma read request
  output sdp_rdma_ig_pkg::sdp_rdma_ig_dma_req_t dma_rd_req,
  output logic                                  dma_rd_req_vld,
  input  logic                                  dma_rd_req_rdy,
  // context queue
  output sdp_rdma_ig_pkg::sdp_rdma_ig_cq_req_t  cq_req,
  output logic                                  cq_vld,
  input  logic                                  cq_rdy,
  // perf
  output logic [`SDP_RDMA_STALL_WIDTH-1:0]      rdma_stall
);

  logic [`SDP_RDMA_SURF_WIDTH-1:0]    last_surf;
  logic [`SDP_RDMA_SIZE_WIDTH-1:0]    req_size;
  logic [`SDP_RDMA_ADDR_WIDTH-1:0]    req_addr;
  logic                               accept;
  sdp_rdma_ig_pkg::sdp_rdma_ig_walk_t walk;

  // ============================================================
  // blocks
  // ============================================================
  sdp_rdma_ig_size_calc u_size_calc (
    .cfg       (cfg),
    .last_surf (last_surf),
    .req_size  (req_size)
  );

  sdp_rdma_ig_cube_walker u_cube_walker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cfg             (cfg),
    .last_surf       (last_surf),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .cq_rdy          (cq_rdy),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .cq_vld          (cq_vld),
    .accept          (accept),
    .walk            (walk)
  );

  sdp_rdma_ig_addr_gen u_addr_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cfg             (cfg),
    .accept          (accept),
    .walk            (walk),
    .req_addr        (req_addr)
  );

  sdp_rdma_ig_stall_cnt u_stall_cnt (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cfg             (cfg),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .rdma_stall      (rdma_stall)
  );

  // ============================================================
  // request payloads
  // ============================================================
  // same size goes to dma and to the egress context
  assign dma_rd_req.addr = req_addr;
  assign dma_rd_req.size = req_size;
  assign cq_req.size     = req_size;
  assign cq_req.cube_end = walk.cube_end;

endmodule

// File: sdp_rdma_ig_stall_cnt.sv
/*
 * perf counter of cycles where a dma read request waits for ready
 */
`timescale 1ns/1ps
`include "sdp_rdma_ig_cfg.svh"

module sdp_rdma_ig_stall_cnt (
  input  logic                               nvdla_core_clk,
  input  logic                               nvdla_core_rstn,
  input  logic                               op_load,
  input  sdp_rdma_ig_pkg::sdp_rdma_ig_cfg_t  cfg,
  input  logic                               dma_rd_req_vld,
  input  logic                               dma_rd_req_rdy,
  output logic [`SDP_RDMA_STALL_WIDTH-1:0]   rdma_stall
);

  logic cnt_en;
  logic stall_cyc;

  // counter only moves with both enables set
  assign cnt_en    = cfg.op_en & cfg.perf_dma_en;
  assign stall_cyc = dma_rd_req_vld & ~dma_rd_req_rdy;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      rdma_stall <= '0;
    end else if (cnt_en) begin
      // new operation restarts the count
      if (op_load) begin
        rdma_stall <= '0;
      end else if (stall_cyc) begin
        rdma_stall <= rdma_stall + 1'b1;
      end
    end
  end

endmodule

// File: sdp_rdma_ig_addr_gen.sv
/*
 * line and surface base addresses and the byte address of each request
 */
`timescale 1ns/1ps
`include "sdp_rdma_ig_cfg.svh"

module sdp_rdma_ig_addr_gen (
  input  logic                                nvdla_core_clk,
  input  logic                                nvdla_core_rstn,
  input  logic                                op_load,
  input  sdp_rdma_ig_pkg::sdp_rdma_ig_cfg_t   cfg,
  input  logic                                accept,
  input  sdp_rdma_ig_pkg::sdp_rdma_ig_walk_t  walk,
  output logic [`SDP_RDMA_ADDR_WIDTH-1:0]     req_addr
);

  // bases kept in atoms
  logic [`SDP_RDMA_ADDR_WIDTH-`SDP_RDMA_ATOM_SHIFT-1:0] line_base;
  logic [`SDP_RDMA_ADDR_WIDTH-`SDP_RDMA_ATOM_SHIFT-1:0] surf_base;
  logic [`SDP_RDMA_ADDR_WIDTH-`SDP_RDMA_ATOM_SHIFT-1:0] next_surf;

  // start of the following surface
  assign next_surf = surf_base + cfg.surf_stride;

  // ============================================================
  // base registers
  // ============================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      line_base <= '0;
      surf_base <= '0;
    end else if (op_load) begin
      line_base <= cfg.base_addr;
      surf_base <= cfg.base_addr;
    end else if (accept) begin
      if (walk.surf_end) begin
        // jump to next surface, first line
        line_base <= next_surf;
        surf_base <= next_surf;
      end else begin
        line_base <= line_base + cfg.line_stride;
      end
    end
  end

  // atom address to byte address
  assign req_addr = {line_base, {`SDP_RDMA_ATOM_SHIFT{1'b0}}};

endmodule

// File: sdp_rdma_ig_cube_walker.sv
/*
 * operation state, channel surface and line counters of the cube walk
 * cross-coupled valid/ready pairing of the dma and context queue ports
 */
`timescale 1ns/1ps
`include "sdp_rdma_ig_cfg.svh"

module sdp_rdma_ig_cube_walker (
  input  logic                                nvdla_core_clk,
  input  logic                                nvdla_core_rstn,
  input  logic                                op_load,
  input  sdp_rdma_ig_pkg::sdp_rdma_ig_cfg_t   cfg,
  input  logic [`SDP_RDMA_SURF_WIDTH-1:0]     last_surf,
  input  logic                                dma_rd_req_rdy,
  input  logic                                cq_rdy,
  output logic                                dma_rd_req_vld,
  output logic                                cq_vld,
  output logic                                accept,
  output sdp_rdma_ig_pkg::sdp_rdma_ig_walk_t  walk
);

  logic                            op_active;
  logic [`SDP_RDMA_SURF_WIDTH-1:0] cnt_c;
  logic [`SDP_RDMA_DIM_WIDTH-1:0]  cnt_h;
  logic                            single_req;
  logic                            last_h;
  logic                            last_c;

  // ============================================================
  // cube position
  // ============================================================
  assign single_req = (cfg.data_mode == 1'b0) |
                      ((cfg.width == '0) & (cfg.height == '0));
  assign last_h = (cnt_h == cfg.height);
  assign last_c = (cnt_c == last_surf);

  // one line per request, so a surface ends at its last line
  assign walk.surf_end = single_req | last_h;
  assign walk.cube_end = single_req | (last_h & last_c);

  // ============================================================
  // paired handshake
  // ============================================================
  // each valid waits on the other side's ready
  // so both transfers land in the same cycle
  assign dma_rd_req_vld = op_active & cq_rdy;
  assign cq_vld         = op_active & dma_rd_req_rdy;
  assign accept         = dma_rd_req_vld & dma_rd_req_rdy;

  // busy from op_load until the cube end is taken
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_active <= 1'b0;
    end else if (op_load) begin
      op_active <= 1'b1;
    end else if (accept && walk.cube_end) begin
      op_active <= 1'b0;
    end
  end

  // ============================================================
  // counters
  // ============================================================
  // line within the surface
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt_h <= '0;
    end else if (op_load) begin
      cnt_h <= '0;
    end else if (accept) begin
      if (walk.surf_end) begin
        cnt_h <= '0;
      end else begin
        cnt_h <= cnt_h + 1'b1;
      end
    end
  end

  // channel surface within the cube
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt_c <= '0;
    end else if (op_load) begin
      cnt_c <= '0;
    end else if (accept) begin
      if (walk.cube_end) begin
        cnt_c <= '0;
      end else if (walk.surf_end) begin
        cnt_c <= cnt_c + 1'b1;
      end
    end
  end

endmodule

// File: sdp_rdma_ig_size_calc.sv
/*
 * surface count and request size in atoms for every precision and data layout
 */
`timescale 1ns/1ps
`include "sdp_rdma_ig_cfg.svh"

module sdp_rdma_ig_size_calc (
  input  sdp_rdma_ig_pkg::sdp_rdma_ig_cfg_t cfg,
  output logic [`SDP_RDMA_SURF_WIDTH-1:0]   last_surf,
  output logic [`SDP_RDMA_SIZE_WIDTH-1:0]   req_size
);

  logic       is_int8;
  logic       size_1byte;
  logic       use_both;
  logic       single_req;
  // log2 of the element factor, 0 1 or 2
  logic [1:0] k_shift;
  // atoms per element before scaling
  logic [`SDP_RDMA_SIZE_WIDTH-1:0] unit_cnt;

  // ============================================================
  // config decode
  // ============================================================
  assign is_int8    = (cfg.precision == `SDP_RDMA_PREC_INT8);
  assign size_1byte = (cfg.data_size == 1'b0);
  assign use_both   = (cfg.data_use == 2'd2);
  // per kernel or 1x1 pack sends one request for the whole cube
  assign single_req = (cfg.data_mode == 1'b0) |
                      ((cfg.width == '0) & (cfg.height == '0));

  // ============================================================
  // surfaces per cube
  // ============================================================
  // 8 channels per surface for int8, 4 otherwise
  always_comb begin
    if (is_int8) begin
      last_surf = {1'b0, cfg.channel[`SDP_RDMA_DIM_WIDTH-1:3]};
    end else begin
      last_surf = cfg.channel[`SDP_RDMA_DIM_WIDTH-1:2];
    end
  end

  // ============================================================
  // element factor
  // ============================================================
  always_comb begin
    if (is_int8) begin
      if (use_both) begin
        // 2 or 4 bytes per element
        k_shift = size_1byte ? 2'd1 : 2'd2;
      end else begin
        // 1 or 2 bytes per element
        k_shift = size_1byte ? 2'd0 : 2'd1;
      end
    end else begin
      // int16 data is 2 bytes already, both doubles it
      k_shift = use_both ? 2'd1 : 2'd0;
    end
  end

  // ============================================================
  // request size
  // ============================================================
  // single request covers every surface, otherwise one line
  always_comb begin
    if (single_req) begin
      unit_cnt = `SDP_RDMA_SIZE_WIDTH'(last_surf) + 1'b1;
    end else begin
      unit_cnt = `SDP_RDMA_SIZE_WIDTH'(cfg.width) + 1'b1;
    end
  end

  // scaled count back to minus-one encoding
  assign req_size = (unit_cnt << k_shift) - 1'b1;

endmodule

// File: sdp_rdma_ig_pkg.sv
/*
 * shared types of the sdp rdma ingress command generator
 * register configuration, dma request, context queue entry, walk flags
 */
`include "sdp_rdma_ig_cfg.svh"

package sdp_rdma_ig_pkg;

  // ============================================================
  // register configuration
  // ============================================================
  typedef struct packed {
    // cube shape, all fields hold size minus one
    logic [`SDP_RDMA_DIM_WIDTH-1:0] channel;
    logic [`SDP_RDMA_DIM_WIDTH-1:0] height;
    logic [`SDP_RDMA_DIM_WIDTH-1:0] width;
    // 0 int8, 1 int16
    logic [1:0] precision;
    // 0 per kernel, 1 per element
    logic data_mode;
    // 0 one byte, 1 two bytes
    logic data_size;
    // 2 means both operands are read
    logic [1:0] data_use;
    // addresses and strides in 8-byte atoms
    logic [`SDP_RDMA_ADDR_WIDTH-`SDP_RDMA_ATOM_SHIFT-1:0] base_addr;
    logic [`SDP_RDMA_ADDR_WIDTH-`SDP_RDMA_ATOM_SHIFT-1:0] line_stride;
    logic [`SDP_RDMA_ADDR_WIDTH-`SDP_RDMA_ATOM_SHIFT-1:0] surf_stride;
    // operation and perf counter enables
    logic op_en;
    logic perf_dma_en;
  } sdp_rdma_ig_cfg_t;

  // ============================================================
  // outgoing requests
  // ============================================================
  // dma read request, size in the upper bits
  typedef struct packed {
    logic [`SDP_RDMA_SIZE_WIDTH-1:0] size;
    logic [`SDP_RDMA_ADDR_WIDTH-1:0] addr;
  } sdp_rdma_ig_dma_req_t;

  // context queue entry for the egress side
  typedef struct packed {
    logic cube_end;
    logic [`SDP_RDMA_SIZE_WIDTH-1:0] size;
  } sdp_rdma_ig_cq_req_t;

  // position of the current request within the cube
  typedef struct packed {
    logic surf_end;
    logic cube_end;
  } sdp_rdma_ig_walk_t;

endpackage

// File: sdp_rdma_ig_cfg.svh
/*
 * widths, atom shift and precision codes for the sdp rdma ingress command generator
 */
`ifndef SDP_RDMA_IG_CFG_SVH
`define SDP_RDMA_IG_CFG_SVH

// byte address of a dma read request
`define SDP_RDMA_ADDR_WIDTH 32

// log2 of the 8-byte atom
// stored bases and strides drop these low bits
`define SDP_RDMA_ATOM_SHIFT 3

// request size field, atom count minus one
`define SDP_RDMA_SIZE_WIDTH 15

// channel, height and width register fields
`define SDP_RDMA_DIM_WIDTH 13

// channel surface counter
`define SDP_RDMA_SURF_WIDTH 11

// performance stall counter
`define SDP_RDMA_STALL_WIDTH 32

// precision codes, anything other than int8 walks like int16
`define SDP_RDMA_PREC_INT8 2'd0
`define SDP_RDMA_PREC_INT16 2'd1

`endif
